//--- Bender.yml
package:
  name: id_stage

sources:
  - include_dirs:
      - source
    files:
      - source/id_isa_pkg.sv
      - source/id_ctrl_pkg.sv
      - source/id_control.sv
      - source/id_operand_bypass.sv
      - source/id_branch_unit.sv
      - source/id_stage.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/tb_id_stage.sv

//--- sim/tb_id_stage.sv
`include "id_params.svh"

module tb_id_stage
	import id_isa_pkg::*;
	import id_ctrl_pkg::*;
;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD  = 100;
	localparam int NUM_VECTORS = 40;

	// Reference addresses and data
	localparam word_t PC_A  = 32'h0040_0100;
	localparam word_t PC_J  = 32'h8000_0200;
	localparam word_t RF_A  = 32'h1234_5678;
	localparam word_t RF_B  = 32'h0bad_f00d;
	localparam word_t EX_D  = 32'hee00_0001;
	localparam word_t MEM_D = 32'hdd00_0002;

	// Expected addresses for branches and EPC
	localparam word_t PC_A4    = PC_A - `ID_INST_BYTES;
	localparam word_t TGT_FWD  = PC_A + `ID_INST_BYTES + (32'd16 << 2);
	localparam word_t TGT_BACK = PC_A + `ID_INST_BYTES - (32'd16 << 2);
	localparam word_t LINK_A   = PC_A + 2 * `ID_INST_BYTES;
	localparam word_t PC_J4    = PC_J + `ID_INST_BYTES;
	localparam word_t J_TGT    = {PC_J4[31:28], 26'h012_3456, 2'b00};
	localparam word_t LINK_J   = PC_J + 2 * `ID_INST_BYTES;

	typedef struct packed {
		logic      rst_n;
		word_t     inst;
		word_t     pc;
		logic      in_delay;
		word_t     rf1;
		word_t     rf2;
		logic      ex_wreg;
		reg_addr_t ex_wd;
		word_t     ex_wdata;
		logic      mem_wreg;
		reg_addr_t mem_wd;
		word_t     mem_wdata;
		logic [2:0] ex_sel;
		logic [2:0] exp_sel;
		logic [7:0] exp_op;
		reg_addr_t exp_wd;
		logic      exp_wreg;
		word_t     exp_reg1;
		word_t     exp_reg2;
		logic      exp_branch;
		word_t     exp_target;
		word_t     exp_link;
		logic      exp_next_delay;
		logic [4:0] exp_exc;
		word_t     exp_epc;
		logic      exp_stall;
		logic      exp_read1;
		reg_addr_t exp_addr1;
		logic      exp_read2;
		reg_addr_t exp_addr2;
	} vector_t;

	//////////////////////////////////////////////////////////////////////
	// Stimulus first, then expected outputs, then expected read ports
	//////////////////////////////////////////////////////////////////////

	localparam vector_t VECTORS [NUM_VECTORS] = '{
		// Reset holds NOP outputs
		'{'0, 32'h00221821, PC_A, '1, RF_A, RF_B, '1, 5'd1, EX_D, '1, 5'd2, MEM_D, SEL_MEM,
		  SEL_SHIFT, ALU_SLL, 5'd0, '0, '0, '0, '0, '0, '0, '0, EXC_NONE, '0, '0,
		  '0, 5'd0, '0, 5'd0},
		'{'0, 32'h0c123456, PC_J, '0, RF_A, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_MEM,
		  SEL_SHIFT, ALU_SLL, 5'd0, '0, '0, '0, '0, '0, '0, '0, EXC_NONE, '0, '0,
		  '0, 5'd0, '0, 5'd0},
		// Decode
		'{'1, 32'h00221821, PC_A, '0, RF_A, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_ARITH, ALU_ADDU, 5'd3, '1, RF_A, RF_B, '0, '0, '0, '0, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '1, 5'd2},
		'{'1, 32'h00221824, PC_A, '0, RF_A, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_LOGIC,
		  SEL_LOGIC, ALU_AND, 5'd3, '1, RF_A, RF_B, '0, '0, '0, '0, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '1, 5'd2},
		'{'1, 32'h00021900, PC_A, '0, RF_A, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_SHIFT, ALU_SLL, 5'd3, '1, RF_A, 32'h4, '0, '0, '0, '0, EXC_NONE, PC_A, '0,
		  '1, 5'd2, '0, 5'd2},
		'{'1, 32'h34228001, PC_A, '0, RF_A, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_TRAP,
		  SEL_LOGIC, ALU_ORI, 5'd2, '1, RF_A, 32'h8001, '0, '0, '0, '0, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '0, 5'd2},
		'{'1, 32'h3c021234, PC_A, '0, RF_A, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_LOGIC, ALU_LUI, 5'd2, '1, 32'h1234, 32'h1234, '0, '0, '0, '0, EXC_NONE, PC_A, '0,
		  '0, 5'd0, '0, 5'd2},
		'{'1, 32'h2022fffc, PC_A, '0, RF_A, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_ARITH,
		  SEL_ARITH, ALU_ADDI, 5'd2, '1, RF_A, 32'hfffffffc, '0, '0, '0, '0, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '0, 5'd2},
		'{'1, 32'h8c22fff8, PC_A, '0, RF_A, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_MEM, ALU_LW, 5'd2, '1, RF_A, 32'hfffffff8, '0, '0, '0, '0, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '0, 5'd2},
		'{'1, 32'hac220010, PC_A, '0, RF_A, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_BRANCH,
		  SEL_MEM, ALU_SW, 5'd2, '0, RF_A, RF_B, '0, '0, '0, '0, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '1, 5'd2},
		// Forwarding priority
		'{'1, 32'h00221821, PC_A, '0, RF_A, RF_B, '1, 5'd1, EX_D, '1, 5'd1, MEM_D, SEL_SHIFT,
		  SEL_ARITH, ALU_ADDU, 5'd3, '1, EX_D, RF_B, '0, '0, '0, '0, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '1, 5'd2},
		'{'1, 32'h00221821, PC_A, '0, RF_A, RF_B, '0, 5'd2, EX_D, '1, 5'd2, MEM_D, SEL_SHIFT,
		  SEL_ARITH, ALU_ADDU, 5'd3, '1, RF_A, MEM_D, '0, '0, '0, '0, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '1, 5'd2},
		'{'1, 32'h00221821, PC_A, '0, RF_A, RF_B, '1, 5'd2, EX_D, '1, 5'd1, MEM_D, SEL_SHIFT,
		  SEL_ARITH, ALU_ADDU, 5'd3, '1, MEM_D, EX_D, '0, '0, '0, '0, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '1, 5'd2},
		// Conditional branches taken then not taken
		'{'1, 32'h10220010, PC_A, '0, 32'h55, 32'h55, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_BRANCH, ALU_BEQ, 5'd2, '0, 32'h55, 32'h55, '1, TGT_FWD, '0, '1, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '1, 5'd2},
		'{'1, 32'h10220010, PC_A, '0, 32'h55, 32'h56, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_BRANCH, ALU_BEQ, 5'd2, '0, 32'h55, 32'h56, '0, '0, '0, '1, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '1, 5'd2},
		'{'1, 32'h1422fff0, PC_A, '0, 32'h55, 32'h56, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_BRANCH, ALU_BNE, 5'd2, '0, 32'h55, 32'h56, '1, TGT_BACK, '0, '1, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '1, 5'd2},
		'{'1, 32'h1422fff0, PC_A, '0, 32'h55, 32'h55, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_BRANCH, ALU_BNE, 5'd2, '0, 32'h55, 32'h55, '0, '0, '0, '1, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '1, 5'd2},
		'{'1, 32'h1c200010, PC_A, '0, 32'h1, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_BRANCH, ALU_BGTZ, 5'd0, '0, 32'h1, '0, '1, TGT_FWD, '0, '1, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '0, 5'd0},
		'{'1, 32'h1c200010, PC_A, '0, 32'h0, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_BRANCH, ALU_BGTZ, 5'd0, '0, 32'h0, '0, '0, '0, '0, '1, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '0, 5'd0},
		'{'1, 32'h18200010, PC_A, '0, 32'h80000000, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_BRANCH, ALU_BLEZ, 5'd0, '0, 32'h80000000, '0, '1, TGT_FWD, '0, '1, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '0, 5'd0},
		'{'1, 32'h18200010, PC_A, '0, 32'h5, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_BRANCH, ALU_BLEZ, 5'd0, '0, 32'h5, '0, '0, '0, '0, '1, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '0, 5'd0},
		'{'1, 32'h04200010, PC_A, '0, 32'hffffffff, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_BRANCH, ALU_BLTZ, 5'd31, '0, 32'hffffffff, '0, '1, TGT_FWD, '0, '1, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '0, 5'd0},
		'{'1, 32'h04200010, PC_A, '0, 32'h0, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_BRANCH, ALU_BLTZ, 5'd31, '0, 32'h0, '0, '0, '0, '0, '1, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '0, 5'd0},
		'{'1, 32'h04210010, PC_A, '0, 32'h0, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_BRANCH, ALU_BGEZ, 5'd31, '0, 32'h0, '0, '1, TGT_FWD, '0, '1, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '0, 5'd1},
		'{'1, 32'h04210010, PC_A, '0, 32'h80000000, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_BRANCH, ALU_BGEZ, 5'd31, '0, 32'h80000000, '0, '0, '0, '0, '1, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '0, 5'd1},
		// Linking branches write r31 whether taken or not
		'{'1, 32'h04300010, PC_A, '0, 32'hfffffff0, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_BRANCH, ALU_BLTZAL, 5'd31, '1, 32'hfffffff0, '0, '1, TGT_FWD, LINK_A, '1,
		  EXC_NONE, PC_A, '0,
		  '1, 5'd1, '0, 5'd16},
		'{'1, 32'h04300010, PC_A, '0, 32'h10, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_BRANCH, ALU_BLTZAL, 5'd31, '1, 32'h10, '0, '0, '0, LINK_A, '1, EXC_NONE, PC_A, '0,
		  '1, 5'd1, '0, 5'd16},
		'{'1, 32'h04310010, PC_A, '0, 32'h7fffffff, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_BRANCH, ALU_BGEZAL, 5'd31, '1, 32'h7fffffff, '0, '1, TGT_FWD, LINK_A, '1,
		  EXC_NONE, PC_A, '0,
		  '1, 5'd1, '0, 5'd17},
		'{'1, 32'h04310010, PC_A, '0, 32'h80000001, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_BRANCH, ALU_BGEZAL, 5'd31, '1, 32'h80000001, '0, '0, '0, LINK_A, '1,
		  EXC_NONE, PC_A, '0,
		  '1, 5'd1, '0, 5'd17},
		// Jumps
		'{'1, 32'h08123456, PC_J, '0, RF_A, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_BRANCH, ALU_J, 5'd31, '0, '0, '0, '1, J_TGT, '0, '1, EXC_NONE, PC_J, '0,
		  '0, 5'd0, '0, 5'd18},
		'{'1, 32'h0c123456, PC_J, '0, RF_A, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_BRANCH, ALU_JAL, 5'd31, '1, '0, '0, '1, J_TGT, LINK_J, '1, EXC_NONE, PC_J, '0,
		  '0, 5'd0, '0, 5'd18},
		'{'1, 32'h00200008, PC_A, '0, 32'h00402000, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_BRANCH, ALU_JR, 5'd0, '0, 32'h00402000, '0, '1, 32'h00402000, '0, '1,
		  EXC_NONE, PC_A, '0,
		  '1, 5'd1, '0, 5'd0},
		'{'1, 32'h00202009, PC_A, '0, 32'h00402000, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_BRANCH, ALU_JALR, 5'd4, '1, 32'h00402000, '0, '1, 32'h00402000, LINK_A, '1,
		  EXC_NONE, PC_A, '0,
		  '1, 5'd1, '0, 5'd0},
		'{'1, 32'h00202009, PC_A, '0, 32'h00402000, RF_B, '1, 5'd1, 32'h00403000, '0, 5'd0, '0,
		  SEL_SHIFT,
		  SEL_BRANCH, ALU_JALR, 5'd4, '1, 32'h00403000, '0, '1, 32'h00403000, LINK_A, '1,
		  EXC_NONE, PC_A, '0,
		  '1, 5'd1, '0, 5'd0},
		// Exceptions and EPC
		'{'1, 32'h0000000c, PC_A, '0, RF_A, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_TRAP, ALU_SYSCALL, 5'd0, '0, '0, '0, '0, '0, '0, '0, EXC_SYS, PC_A, '0,
		  '0, 5'd0, '0, 5'd0},
		'{'1, 32'h0000000d, PC_A, '1, RF_A, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_TRAP, ALU_BREAK, 5'd0, '0, '0, '0, '0, '0, '0, '0, EXC_BP, PC_A4, '0,
		  '0, 5'd0, '0, 5'd0},
		'{'1, 32'hfc000000, PC_A, '0, RF_A, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_SHIFT, ALU_SLL, 5'd0, '0, '0, '0, '0, '0, '0, '0, EXC_RI, PC_A, '0,
		  '0, 5'd0, '0, 5'd0},
		'{'1, 32'hfc000000, PC_A, '1, RF_A, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_SHIFT,
		  SEL_SHIFT, ALU_SLL, 5'd0, '0, '0, '0, '0, '0, '0, '0, EXC_RI, PC_A4, '0,
		  '0, 5'd0, '0, 5'd0},
		// Stall follows the EX class only
		'{'1, 32'h00221821, PC_A, '0, RF_A, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_MEM,
		  SEL_ARITH, ALU_ADDU, 5'd3, '1, RF_A, RF_B, '0, '0, '0, '0, EXC_NONE, PC_A, '1,
		  '1, 5'd1, '1, 5'd2},
		'{'1, 32'h0000000c, PC_A, '1, RF_A, RF_B, '0, 5'd0, '0, '0, 5'd0, '0, SEL_MEM,
		  SEL_TRAP, ALU_SYSCALL, 5'd0, '0, '0, '0, '0, '0, '0, '0, EXC_SYS, PC_A4, '1,
		  '0, 5'd0, '0, 5'd0}
	};

	logic      clk;
	logic      rst_n;
	word_t     inst;
	word_t     pc;
	logic      in_delay;
	word_t     reg1_data;
	word_t     reg2_data;
	logic      ex_wreg;
	reg_addr_t ex_wd;
	word_t     ex_wdata;
	logic      mem_wreg;
	reg_addr_t mem_wd;
	word_t     mem_wdata;
	alu_sel_e  ex_alu_sel;

	alu_sel_e  alu_sel;
	alu_op_e   alu_op;
	reg_addr_t wd;
	logic      wreg;
	logic      reg1_read;
	reg_addr_t reg1_addr;
	logic      reg2_read;
	reg_addr_t reg2_addr;
	word_t     reg1;
	word_t     reg2;
	logic      branch;
	word_t     branch_addr;
	word_t     link_addr;
	logic      next_in_delay;
	exc_code_e exc_code;
	word_t     exc_epc;
	logic      stall;

	int errors;
	int vec_idx;

	id_stage u_dut (
		.rst_n_i         (rst_n),
		.inst_i          (inst),
		.pc_i            (pc),
		.in_delay_i      (in_delay),
		.reg1_data_i     (reg1_data),
		.reg2_data_i     (reg2_data),
		.ex_wreg_i       (ex_wreg),
		.ex_wd_i         (ex_wd),
		.ex_wdata_i      (ex_wdata),
		.mem_wreg_i      (mem_wreg),
		.mem_wd_i        (mem_wd),
		.mem_wdata_i     (mem_wdata),
		.ex_alu_sel_i    (ex_alu_sel),
		.alu_sel_o       (alu_sel),
		.alu_op_o        (alu_op),
		.wd_o            (wd),
		.wreg_o          (wreg),
		.reg1_read_o     (reg1_read),
		.reg1_addr_o     (reg1_addr),
		.reg2_read_o     (reg2_read),
		.reg2_addr_o     (reg2_addr),
		.reg1_o          (reg1),
		.reg2_o          (reg2),
		.branch_o        (branch),
		.branch_addr_o   (branch_addr),
		.link_addr_o     (link_addr),
		.next_in_delay_o (next_in_delay),
		.exc_code_o      (exc_code),
		.exc_epc_o       (exc_epc),
		.stall_o         (stall)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAILED vector %0d: %s expected %h got %h", vec_idx, name, expected, actual);
			errors++;
		end
	endtask

	task automatic apply_stimulus(input vector_t v);
		rst_n      = v.rst_n;
		inst       = v.inst;
		pc         = v.pc;
		in_delay   = v.in_delay;
		reg1_data  = v.rf1;
		reg2_data  = v.rf2;
		ex_wreg    = v.ex_wreg;
		ex_wd      = v.ex_wd;
		ex_wdata   = v.ex_wdata;
		mem_wreg   = v.mem_wreg;
		mem_wd     = v.mem_wd;
		mem_wdata  = v.mem_wdata;
		ex_alu_sel = alu_sel_e'(v.ex_sel);
	endtask

	task automatic check_outputs(input vector_t v);
		check_value("alu_sel_o", 32'(v.exp_sel), 32'(alu_sel));
		check_value("alu_op_o", 32'(v.exp_op), 32'(alu_op));
		check_value("wd_o", 32'(v.exp_wd), 32'(wd));
		check_value("wreg_o", 32'(v.exp_wreg), 32'(wreg));
		check_value("reg1_o", v.exp_reg1, reg1);
		check_value("reg2_o", v.exp_reg2, reg2);
		check_value("branch_o", 32'(v.exp_branch), 32'(branch));
		check_value("branch_addr_o", v.exp_target, branch_addr);
		check_value("link_addr_o", v.exp_link, link_addr);
		check_value("next_in_delay_o", 32'(v.exp_next_delay), 32'(next_in_delay));
		check_value("exc_code_o", 32'(v.exp_exc), 32'(exc_code));
		check_value("exc_epc_o", v.exp_epc, exc_epc);
		check_value("stall_o", 32'(v.exp_stall), 32'(stall));
		check_value("reg1_read_o", 32'(v.exp_read1), 32'(reg1_read));
		check_value("reg1_addr_o", 32'(v.exp_addr1), 32'(reg1_addr));
		check_value("reg2_read_o", 32'(v.exp_read2), 32'(reg2_read));
		check_value("reg2_addr_o", 32'(v.exp_addr2), 32'(reg2_addr));
	endtask

	// Watchdog
	initial begin
		#((NUM_VECTORS + 10) * CLK_PERIOD);
		$display("Timeout: the vector loop did not finish in time");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		errors     = 0;
		vec_idx    = 0;
		rst_n      = 1'b0;
		inst       = '0;
		pc         = '0;
		in_delay   = 1'b0;
		reg1_data  = '0;
		reg2_data  = '0;
		ex_wreg    = 1'b0;
		ex_wd      = '0;
		ex_wdata   = '0;
		mem_wreg   = 1'b0;
		mem_wd     = '0;
		mem_wdata  = '0;
		ex_alu_sel = SEL_SHIFT;

		// The first two vectors keep reset low
		for (int i = 0; i < NUM_VECTORS; i++) begin
			@(posedge clk);
			#1;
			vec_idx = i;
			apply_stimulus(VECTORS[i]);
			@(negedge clk);
			check_outputs(VECTORS[i]);
		end

		$display("Done: %0d vectors, %0d errors", NUM_VECTORS, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- source/id_branch_unit.sv
`include "id_params.svh"

module id_branch_unit
	import id_isa_pkg::*;
	import id_ctrl_pkg::*;
(
	input  branch_kind_e branch_kind_i,
	input  word_t        pc_i,
	input  word_t        inst_i,
	input  word_t        reg1_i,
	input  word_t        reg2_i,
	output logic         branch_o,
	output word_t        branch_addr_o,
	output word_t        link_addr_o,
	output logic         next_in_delay_o
);

	word_t pc_plus4;
	word_t pc_plus8;
	word_t rel_target;
	word_t abs_target;
	word_t target;
	logic  reg1_neg;
	logic  reg1_zero;

	assign pc_plus4 = pc_i + word_t'(`ID_INST_BYTES);
	assign pc_plus8 = pc_plus4 + word_t'(`ID_INST_BYTES);

	// Offset counts instructions relative to the delay slot
	assign rel_target = pc_plus4 + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};

	// Region of the delay slot plus the 26-bit index
	assign abs_target = {pc_plus4[31:28], inst_i[25:0], 2'b00};

	assign reg1_neg  = reg1_i[`ID_DATA_W-1];
	assign reg1_zero = (reg1_i == '0);

	//////////////////////////////////////////////////////////////////////
	// Condition and target
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (branch_kind_i)
			BR_J, BR_JAL, BR_JR, BR_JALR: branch_o = 1'b1;
			BR_EQ:                        branch_o = (reg1_i == reg2_i);
			BR_NE:                        branch_o = (reg1_i != reg2_i);
			BR_GTZ:                       branch_o = !reg1_neg && !reg1_zero;
			BR_LEZ:                       branch_o = reg1_neg || reg1_zero;
			BR_LTZ, BR_LTZAL:             branch_o = reg1_neg;
			BR_GEZ, BR_GEZAL:             branch_o = !reg1_neg;
			default:                      branch_o = 1'b0;
		endcase
	end

	always_comb begin
		case (branch_kind_i)
			BR_J, BR_JAL:   target = abs_target;
			BR_JR, BR_JALR: target = reg1_i;
			default:        target = rel_target;
		endcase
	end

	assign branch_addr_o = branch_o ? target : '0;

	// Return past the delay slot
	assign link_addr_o = (branch_kind_i inside {BR_JAL, BR_JALR, BR_LTZAL, BR_GEZAL}) ?
	                     pc_plus8 : '0;

	// Every branch has a delay slot, taken or not
	assign next_in_delay_o = (branch_kind_i != BR_NONE);

endmodule

//--- source/id_control.sv
`include "id_params.svh"

module id_control
	import id_isa_pkg::*;
	import id_ctrl_pkg::*;
(
	input  logic         rst_n_i,
	input  word_t        inst_i,
	input  word_t        pc_i,
	input  logic         in_delay_i,
	input  alu_sel_e     ex_alu_sel_i,
	output alu_sel_e     alu_sel_o,
	output alu_op_e      alu_op_o,
	output reg_addr_t    wd_o,
	output logic         wreg_o,
	output logic         reg1_read_o,
	output reg_addr_t    reg1_addr_o,
	output logic         reg2_read_o,
	output reg_addr_t    reg2_addr_o,
	output word_t        imm_o,
	output branch_kind_e branch_kind_o,
	output exc_code_e    exc_code_o,
	output word_t        exc_epc_o,
	output logic         stall_o
);

	localparam reg_addr_t LINK_REG = reg_addr_t'(`ID_LINK_REG);

	opcode_e   opcode;
	funct_e    funct;
	regimm_e   regimm;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	logic [4:0] shamt;
	imm16_t    imm16;
	word_t     zero_imm;
	word_t     sign_imm;
	logic      reserved;

	assign opcode = opcode_e'(inst_i[31:26]);
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign shamt  = inst_i[10:6];
	assign funct  = funct_e'(inst_i[5:0]);
	assign regimm = regimm_e'(inst_i[20:16]);
	assign imm16  = inst_i[15:0];

	assign zero_imm = {16'b0, imm16};
	assign sign_imm = {{16{imm16[15]}}, imm16};

	//////////////////////////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		alu_sel_o     = SEL_SHIFT;
		alu_op_o      = alu_op_e'({2'b01, opcode});
		wd_o          = rt;
		wreg_o        = 1'b0;
		reg1_read_o   = 1'b1;
		reg1_addr_o   = rs;
		reg2_read_o   = 1'b0;
		reg2_addr_o   = rt;
		imm_o         = '0;
		branch_kind_o = BR_NONE;
		exc_code_o    = EXC_NONE;
		reserved      = 1'b0;

		case (opcode)
			OP_SPECIAL: begin
				alu_op_o    = alu_op_e'({2'b00, funct});
				wd_o        = rd;
				wreg_o      = 1'b1;
				reg2_read_o = 1'b1;
				case (funct)
					F_SLL, F_SRL, F_SRA: begin
						reg1_addr_o = rt;
						reg2_read_o = 1'b0;
						imm_o       = word_t'(shamt);
					end
					// Variable shifts take the amount from rs
					F_SLLV, F_SRLV, F_SRAV: begin
						reg1_addr_o = rt;
						reg2_addr_o = rs;
					end
					F_AND, F_OR, F_XOR, F_NOR: alu_sel_o = SEL_LOGIC;
					F_ADD, F_ADDU, F_SUB, F_SUBU, F_SLT, F_SLTU: alu_sel_o = SEL_ARITH;
					F_JR, F_JALR: begin
						alu_sel_o     = SEL_BRANCH;
						wreg_o        = (funct == F_JALR);
						reg2_read_o   = 1'b0;
						branch_kind_o = (funct == F_JALR) ? BR_JALR : BR_JR;
					end
					F_SYSCALL, F_BREAK: begin
						alu_sel_o   = SEL_TRAP;
						wreg_o      = 1'b0;
						reg1_read_o = 1'b0;
						reg2_read_o = 1'b0;
						exc_code_o  = (funct == F_SYSCALL) ? EXC_SYS : EXC_BP;
					end
					default: reserved = 1'b1;
				endcase
			end
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				alu_sel_o   = SEL_LOGIC;
				wreg_o      = 1'b1;
				reg1_read_o = (opcode != OP_LUI);
				imm_o       = zero_imm;
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				alu_sel_o = SEL_ARITH;
				wreg_o    = 1'b1;
				imm_o     = sign_imm;
			end
			OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
				alu_sel_o = SEL_MEM;
				wreg_o    = 1'b1;
				imm_o     = sign_imm;
			end
			// Store data comes from rt
			OP_SB, OP_SH, OP_SW: begin
				alu_sel_o   = SEL_MEM;
				reg2_read_o = 1'b1;
			end
			OP_J, OP_JAL: begin
				alu_sel_o     = SEL_BRANCH;
				reg1_read_o   = 1'b0;
				wreg_o        = (opcode == OP_JAL);
				wd_o          = LINK_REG;
				branch_kind_o = (opcode == OP_JAL) ? BR_JAL : BR_J;
			end
			OP_BEQ, OP_BNE: begin
				alu_sel_o     = SEL_BRANCH;
				reg2_read_o   = 1'b1;
				branch_kind_o = (opcode == OP_BEQ) ? BR_EQ : BR_NE;
			end
			OP_BGTZ, OP_BLEZ: begin
				alu_sel_o     = SEL_BRANCH;
				branch_kind_o = (opcode == OP_BGTZ) ? BR_GTZ : BR_LEZ;
			end
			OP_REGIMM: begin
				alu_sel_o = SEL_BRANCH;
				alu_op_o  = alu_op_e'({3'b100, regimm});
				wd_o      = LINK_REG;
				wreg_o    = (regimm inside {RI_BLTZAL, RI_BGEZAL});
				case (regimm)
					RI_BLTZ:   branch_kind_o = BR_LTZ;
					RI_BGEZ:   branch_kind_o = BR_GEZ;
					RI_BLTZAL: branch_kind_o = BR_LTZAL;
					RI_BGEZAL: branch_kind_o = BR_GEZAL;
					default:   reserved = 1'b1;
				endcase
			end
			default: reserved = 1'b1;
		endcase

		// Reserved encodings and reset both issue a NOP
		if (reserved || !rst_n_i) begin
			alu_sel_o     = SEL_SHIFT;
			alu_op_o      = ALU_SLL;
			wd_o          = '0;
			wreg_o        = 1'b0;
			reg1_read_o   = 1'b0;
			reg1_addr_o   = '0;
			reg2_read_o   = 1'b0;
			reg2_addr_o   = '0;
			imm_o         = '0;
			branch_kind_o = BR_NONE;
			exc_code_o    = reserved ? EXC_RI : EXC_NONE;
		end
		if (!rst_n_i)
			exc_code_o = EXC_NONE;
	end

	// EPC points at the branch when this is its delay slot
	assign exc_epc_o = !rst_n_i   ? '0 :
	                   in_delay_i ? pc_i - word_t'(`ID_INST_BYTES) : pc_i;

	// Load or store in EX
	assign stall_o = rst_n_i && (ex_alu_sel_i == SEL_MEM);

endmodule

//--- source/id_ctrl_pkg.sv
`include "id_params.svh"

package id_ctrl_pkg;

	// Execute unit class
	typedef enum logic [2:0] {
		SEL_SHIFT  = 3'd0,
		SEL_LOGIC  = 3'd1,
		SEL_ARITH  = 3'd2,
		SEL_BRANCH = 3'd3,
		SEL_MEM    = 3'd4,
		SEL_TRAP   = 3'd5
	} alu_sel_e;

	// Operation code
	// [7:6] = 00 for SPECIAL, 01 for major opcodes, 10 for REGIMM;
	// low bits mirror the funct, opcode or rt field
	typedef enum logic [7:0] {
		ALU_SLL     = 8'h00, ALU_SRL    = 8'h02, ALU_SRA    = 8'h03,
		ALU_SLLV    = 8'h04, ALU_SRLV   = 8'h06, ALU_SRAV   = 8'h07,
		ALU_JR      = 8'h08, ALU_JALR   = 8'h09,
		ALU_SYSCALL = 8'h0c, ALU_BREAK  = 8'h0d,
		ALU_ADD     = 8'h20, ALU_ADDU   = 8'h21, ALU_SUB    = 8'h22,
		ALU_SUBU    = 8'h23, ALU_AND    = 8'h24, ALU_OR     = 8'h25,
		ALU_XOR     = 8'h26, ALU_NOR    = 8'h27, ALU_SLT    = 8'h2a,
		ALU_SLTU    = 8'h2b,
		ALU_J       = 8'h42, ALU_JAL    = 8'h43, ALU_BEQ    = 8'h44,
		ALU_BNE     = 8'h45, ALU_BLEZ   = 8'h46, ALU_BGTZ   = 8'h47,
		ALU_ADDI    = 8'h48, ALU_ADDIU  = 8'h49, ALU_SLTI   = 8'h4a,
		ALU_SLTIU   = 8'h4b, ALU_ANDI   = 8'h4c, ALU_ORI    = 8'h4d,
		ALU_XORI    = 8'h4e, ALU_LUI    = 8'h4f,
		ALU_LB      = 8'h60, ALU_LH     = 8'h61, ALU_LW     = 8'h63,
		ALU_LBU     = 8'h64, ALU_LHU    = 8'h65, ALU_SB     = 8'h68,
		ALU_SH      = 8'h69, ALU_SW     = 8'h6b,
		ALU_BLTZ    = 8'h80, ALU_BGEZ   = 8'h81,
		ALU_BLTZAL  = 8'h90, ALU_BGEZAL = 8'h91
	} alu_op_e;

	// Branch class with separate linking forms
	typedef enum logic [3:0] {
		BR_NONE  = 4'd0,
		BR_J     = 4'd1,
		BR_JAL   = 4'd2,
		BR_JR    = 4'd3,
		BR_JALR  = 4'd4,
		BR_EQ    = 4'd5,
		BR_NE    = 4'd6,
		BR_GTZ   = 4'd7,
		BR_LEZ   = 4'd8,
		BR_LTZ   = 4'd9,
		BR_GEZ   = 4'd10,
		BR_LTZAL = 4'd11,
		BR_GEZAL = 4'd12
	} branch_kind_e;

	typedef enum logic [4:0] {
		EXC_NONE = 5'd0,
		EXC_SYS  = 5'd8,
		EXC_BP   = 5'd9,
		EXC_RI   = 5'd10
	} exc_code_e;

endpackage

//--- source/id_isa_pkg.sv
`include "id_params.svh"

package id_isa_pkg;

	typedef logic [`ID_DATA_W-1:0] word_t;
	typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [15:0] imm16_t;

	// Major opcode in inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_REGIMM  = 6'b000001,
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_BLEZ    = 6'b000110,
		OP_BGTZ    = 6'b000111,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111,
		OP_LB      = 6'b100000,
		OP_LH      = 6'b100001,
		OP_LW      = 6'b100011,
		OP_LBU     = 6'b100100,
		OP_LHU     = 6'b100101,
		OP_SB      = 6'b101000,
		OP_SH      = 6'b101001,
		OP_SW      = 6'b101011
	} opcode_e;

	// SPECIAL function in inst[5:0]
	typedef enum logic [5:0] {
		F_SLL     = 6'b000000,
		F_SRL     = 6'b000010,
		F_SRA     = 6'b000011,
		F_SLLV    = 6'b000100,
		F_SRLV    = 6'b000110,
		F_SRAV    = 6'b000111,
		F_JR      = 6'b001000,
		F_JALR    = 6'b001001,
		F_SYSCALL = 6'b001100,
		F_BREAK   = 6'b001101,
		F_ADD     = 6'b100000,
		F_ADDU    = 6'b100001,
		F_SUB     = 6'b100010,
		F_SUBU    = 6'b100011,
		F_AND     = 6'b100100,
		F_OR      = 6'b100101,
		F_XOR     = 6'b100110,
		F_NOR     = 6'b100111,
		F_SLT     = 6'b101010,
		F_SLTU    = 6'b101011
	} funct_e;

	// REGIMM selector in the rt field
	typedef enum logic [4:0] {
		RI_BLTZ   = 5'b00000,
		RI_BGEZ   = 5'b00001,
		RI_BLTZAL = 5'b10000,
		RI_BGEZAL = 5'b10001
	} regimm_e;

endpackage

//--- source/id_operand_bypass.sv
`include "id_params.svh"

module id_operand_bypass
	import id_isa_pkg::*;
(
	input  logic      reg1_read_i,
	input  logic      reg2_read_i,
	input  reg_addr_t reg1_addr_i,
	input  reg_addr_t reg2_addr_i,
	input  word_t     imm_i,
	input  word_t     reg1_data_i,
	input  word_t     reg2_data_i,
	input  logic      ex_wreg_i,
	input  reg_addr_t ex_wd_i,
	input  word_t     ex_wdata_i,
	input  logic      mem_wreg_i,
	input  reg_addr_t mem_wd_i,
	input  word_t     mem_wdata_i,
	output word_t     reg1_o,
	output word_t     reg2_o
);

	// EX data beats MEM data and both beat the register file
	function automatic word_t select_operand(
		input logic      read_en,
		input reg_addr_t addr,
		input word_t     rf_data
	);
		if (read_en && ex_wreg_i && (ex_wd_i == addr))
			return ex_wdata_i;
		else if (read_en && mem_wreg_i && (mem_wd_i == addr))
			return mem_wdata_i;
		else if (read_en)
			return rf_data;
		else
			return imm_i;
	endfunction

	always_comb begin
		reg1_o = select_operand(reg1_read_i, reg1_addr_i, reg1_data_i);
		reg2_o = select_operand(reg2_read_i, reg2_addr_i, reg2_data_i);
	end

endmodule

//--- source/id_params.svh
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////

// Data and address word
`define ID_DATA_W 32

// Register file index
`define ID_REG_ADDR_W 5

//////////////////////////////////////////////////////////////////////
// Architectural constants
//////////////////////////////////////////////////////////////////////

// Written by JAL, BLTZAL and BGEZAL
`define ID_LINK_REG 31

// Byte distance between consecutive instructions
`define ID_INST_BYTES 4

`endif

//--- source/id_stage.sv
`include "id_params.svh"

module id_stage
	import id_isa_pkg::*;
	import id_ctrl_pkg::*;
(
	input  logic      rst_n_i,
	input  word_t     inst_i,
	input  word_t     pc_i,
	input  logic      in_delay_i,
	input  word_t     reg1_data_i,
	input  word_t     reg2_data_i,
	input  logic      ex_wreg_i,
	input  reg_addr_t ex_wd_i,
	input  word_t     ex_wdata_i,
	input  logic      mem_wreg_i,
	input  reg_addr_t mem_wd_i,
	input  word_t     mem_wdata_i,
	input  alu_sel_e  ex_alu_sel_i,
	output alu_sel_e  alu_sel_o,
	output alu_op_e   alu_op_o,
	output reg_addr_t wd_o,
	output logic      wreg_o,
	output logic      reg1_read_o,
	output reg_addr_t reg1_addr_o,
	output logic      reg2_read_o,
	output reg_addr_t reg2_addr_o,
	output word_t     reg1_o,
	output word_t     reg2_o,
	output logic      branch_o,
	output word_t     branch_addr_o,
	output word_t     link_addr_o,
	output logic      next_in_delay_o,
	output exc_code_e exc_code_o,
	output word_t     exc_epc_o,
	output logic      stall_o
);

	word_t        imm;
	branch_kind_e branch_kind;

	id_control u_control (
		.rst_n_i       (rst_n_i),
		.inst_i        (inst_i),
		.pc_i          (pc_i),
		.in_delay_i    (in_delay_i),
		.ex_alu_sel_i  (ex_alu_sel_i),
		.alu_sel_o     (alu_sel_o),
		.alu_op_o      (alu_op_o),
		.wd_o          (wd_o),
		.wreg_o        (wreg_o),
		.reg1_read_o   (reg1_read_o),
		.reg1_addr_o   (reg1_addr_o),
		.reg2_read_o   (reg2_read_o),
		.reg2_addr_o   (reg2_addr_o),
		.imm_o         (imm),
		.branch_kind_o (branch_kind),
		.exc_code_o    (exc_code_o),
		.exc_epc_o     (exc_epc_o),
		.stall_o       (stall_o)
	);

	id_operand_bypass u_bypass (
		.reg1_read_i (reg1_read_o),
		.reg2_read_i (reg2_read_o),
		.reg1_addr_i (reg1_addr_o),
		.reg2_addr_i (reg2_addr_o),
		.imm_i       (imm),
		.reg1_data_i (reg1_data_i),
		.reg2_data_i (reg2_data_i),
		.ex_wreg_i   (ex_wreg_i),
		.ex_wd_i     (ex_wd_i),
		.ex_wdata_i  (ex_wdata_i),
		.mem_wreg_i  (mem_wreg_i),
		.mem_wd_i    (mem_wd_i),
		.mem_wdata_i (mem_wdata_i),
		.reg1_o      (reg1_o),
		.reg2_o      (reg2_o)
	);

	// Conditions see the forwarded operands
	id_branch_unit u_branch (
		.branch_kind_i   (branch_kind),
		.pc_i            (pc_i),
		.inst_i          (inst_i),
		.reg1_i          (reg1_o),
		.reg2_i          (reg2_o),
		.branch_o        (branch_o),
		.branch_addr_o   (branch_addr_o),
		.link_addr_o     (link_addr_o),
		.next_in_delay_o (next_in_delay_o)
	);

endmodule

//--- vlog.f
+incdir+source
source/id_isa_pkg.sv
source/id_ctrl_pkg.sv
source/id_control.sv
source/id_operand_bypass.sv
source/id_branch_unit.sv
source/id_stage.sv
sim/tb_id_stage.sv
